// ==== design/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN 32
`define CORE_NREGS 32
`define CORE_RESET_PC 32'h0000_0000

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_ADDIU 6'h09
`define OP_LUI 6'h0f
`define OP_LW 6'h23
`define OP_SW 6'h2b
`define OP_BEQ 6'h04
`define OP_BNE 6'h05

// funct field of SPECIAL
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_SLT 6'h2a

`endif

// ==== design/mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [31:0] instr_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOp_t;

	typedef enum logic {
		bReg,
		bImm
	} bSel_t;

	// operand source for the execute stage
	typedef enum logic [1:0] {
		fwdRf,
		fwdMem,
		fwdWb
	} fwdSel_t;

	typedef struct packed {
		aluOp_t aluOp;
		bSel_t bSel;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBeq;
		logic isBne;
		regAddr_t dest;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
	} ifId_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		ctrl_t ctrl;
		regAddr_t rs;
		regAddr_t rt;
		word_t rsVal;
		word_t rtVal;
		word_t imm;
	} idEx_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		logic regWrite;
		logic memRead;
		logic memWrite;
		regAddr_t dest;
		word_t result;
		word_t storeData;
	} exMem_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		logic regWrite;
		regAddr_t dest;
		word_t wbData;
	} memWb_t;

endpackage

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module regFile (
	input logic clk,
	input logic arstN,
	input logic [$clog2(`CORE_NREGS)-1:0] rdAddrA,
	input logic [$clog2(`CORE_NREGS)-1:0] rdAddrB,
	output logic [`CORE_XLEN-1:0] rdDataA,
	output logic [`CORE_XLEN-1:0] rdDataB,
	input logic wrEn,
	input logic [$clog2(`CORE_NREGS)-1:0] wrAddr,
	input logic [`CORE_XLEN-1:0] wrData
);
	localparam int AddrW = $clog2(`CORE_NREGS);

	// r0 has no storage
	logic [`CORE_XLEN-1:0] regs [1:`CORE_NREGS-1];

	function automatic logic [`CORE_XLEN-1:0] readPort(logic [AddrW-1:0] addr);
		if (addr == '0)
			return '0;
		// write in flight wins
		if (wrEn && wrAddr == addr)
			return wrData;
		return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < `CORE_NREGS; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	always_comb begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module decoder import mipsPkg::*; (
	input instr_t instr,
	output ctrl_t ctrl,
	output word_t imm
);
	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rt;
	regAddr_t rd;
	logic [15:0] offset;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign offset = instr[15:0];

	// lui places the halfword on top, everything else sign-extends
	assign imm = (opcode == `OP_LUI) ? {offset, 16'h0000} : {{16{offset[15]}}, offset};

	always_comb begin
		ctrl = '0;
		case (opcode)
			`OP_SPECIAL: begin
				ctrl.bSel = bReg;
				ctrl.regWrite = 1'b1;
				ctrl.dest = rd;
				case (funct)
					`FN_ADDU: ctrl.aluOp = aluAdd;
					`FN_SUBU: ctrl.aluOp = aluSub;
					`FN_AND: ctrl.aluOp = aluAnd;
					`FN_OR: ctrl.aluOp = aluOr;
					`FN_SLT: ctrl.aluOp = aluSlt;
					default: ctrl = '0;
				endcase
			end
			`OP_ADDIU: begin
				ctrl.aluOp = aluAdd;
				ctrl.bSel = bImm;
				ctrl.regWrite = 1'b1;
				ctrl.dest = rt;
			end
			`OP_LUI: begin
				ctrl.aluOp = aluLui;
				ctrl.bSel = bImm;
				ctrl.regWrite = 1'b1;
				ctrl.dest = rt;
			end
			`OP_LW: begin
				ctrl.aluOp = aluAdd;
				ctrl.bSel = bImm;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.dest = rt;
			end
			`OP_SW: begin
				ctrl.aluOp = aluAdd;
				ctrl.bSel = bImm;
				ctrl.memWrite = 1'b1;
			end
			`OP_BEQ: begin
				ctrl.aluOp = aluSub;
				ctrl.isBeq = 1'b1;
			end
			`OP_BNE: begin
				ctrl.aluOp = aluSub;
				ctrl.isBne = 1'b1;
			end
			default: ctrl = '0;
		endcase
		// writes to r0 retire silently
		if (ctrl.dest == '0)
			ctrl.regWrite = 1'b0;
	end

endmodule

// ==== design/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input ifId_t ifId,
	input idEx_t idEx,
	input exMem_t exMem,
	input memWb_t memWb,
	input logic dataReq,
	input logic dataOk,
	input logic branchTaken,
	output fwdSel_t fwdA,
	output fwdSel_t fwdB,
	output logic stall,
	output logic memStall,
	output logic flushIf
);
	regAddr_t idRs;
	regAddr_t idRt;
	logic loadUse;

	// MEM result is younger, so it is checked first
	function automatic fwdSel_t pickFwd(regAddr_t src);
		if (src != '0 && exMem.valid && exMem.regWrite && exMem.dest == src)
			return fwdMem;
		if (src != '0 && memWb.valid && memWb.regWrite && memWb.dest == src)
			return fwdWb;
		return fwdRf;
	endfunction

	assign idRs = ifId.instr[25:21];
	assign idRt = ifId.instr[20:16];

	always_comb begin
		fwdA = pickFwd(idEx.rs);
		fwdB = pickFwd(idEx.rt);
	end

	// both source fields are checked, an extra bubble is harmless
	assign loadUse = ifId.valid && idEx.valid && idEx.ctrl.memRead && idEx.ctrl.dest != '0
		&& (idEx.ctrl.dest == idRs || idEx.ctrl.dest == idRt);

	assign stall = loadUse;
	assign memStall = dataReq && !dataOk;
	assign flushIf = branchTaken && !memStall;

	// a branch in EX is never a load, so the two cannot meet
	always_comb begin
		assert (memStall || !(stall && flushIf))
			else $error("load-use stall and branch flush in the same cycle");
	end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import mipsPkg::*; (
	input idEx_t idEx,
	input fwdSel_t fwdA,
	input fwdSel_t fwdB,
	input word_t memFwd,
	input word_t wbFwd,
	output word_t result,
	output word_t storeData,
	output logic branchTaken,
	output word_t branchTarget
);
	word_t opA;
	word_t opRt;
	word_t opB;

	function automatic word_t pickOperand(fwdSel_t sel, word_t rfVal);
		case (sel)
			fwdMem: return memFwd;
			fwdWb: return wbFwd;
			default: return rfVal;
		endcase
	endfunction

	always_comb begin
		opA = pickOperand(fwdA, idEx.rsVal);
		opRt = pickOperand(fwdB, idEx.rtVal);
	end

	assign opB = (idEx.ctrl.bSel == bImm) ? idEx.imm : opRt;
	assign storeData = opRt;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluSlt: result = {31'b0, $signed(opA) < $signed(opB)};
			aluLui: result = idEx.imm;
			default: result = opA + opB;
		endcase
	end

	// target is relative to the delay slot
	assign branchTarget = idEx.pc + 32'd4 + {idEx.imm[29:0], 2'b00};
	assign branchTaken = idEx.valid
		&& ((idEx.ctrl.isBeq && opA == opRt) || (idEx.ctrl.isBne && opA != opRt));

endmodule

// ==== design/mipsCore.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module mipsCore import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	output word_t instrAddr,
	input instr_t instr,
	output logic dataReq,
	output logic dataWe,
	output word_t dataAddr,
	output word_t dataWdata,
	input logic dataOk,
	input word_t dataRdata,
	output word_t debugWbPc,
	output logic [3:0] debugWbRfWen,
	output regAddr_t debugWbRfWnum,
	output word_t debugWbRfWdata
);
	word_t pc;
	ifId_t ifId;
	idEx_t idEx;
	exMem_t exMem;
	memWb_t memWb;
	ctrl_t idCtrl;
	word_t idImm;
	word_t rsVal;
	word_t rtVal;
	fwdSel_t fwdA;
	fwdSel_t fwdB;
	logic stall;
	logic memStall;
	logic flushIf;
	word_t exResult;
	word_t exStoreData;
	word_t branchTarget;
	logic branchTaken;
	logic wbWrite;

	// held WB entry retires only once the data port lets go
	assign wbWrite = memWb.valid && memWb.regWrite && !memStall;

	regFile uRegFile (
		.clk(clk),
		.arstN(arstN),
		.rdAddrA(ifId.instr[25:21]),
		.rdAddrB(ifId.instr[20:16]),
		.rdDataA(rsVal),
		.rdDataB(rtVal),
		.wrEn(wbWrite),
		.wrAddr(memWb.dest),
		.wrData(memWb.wbData)
	);

	decoder uDecoder (
		.instr(ifId.instr),
		.ctrl(idCtrl),
		.imm(idImm)
	);

	hazardUnit uHazard (
		.ifId(ifId),
		.idEx(idEx),
		.exMem(exMem),
		.memWb(memWb),
		.dataReq(dataReq),
		.dataOk(dataOk),
		.branchTaken(branchTaken),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall),
		.memStall(memStall),
		.flushIf(flushIf)
	);

	alu uAlu (
		.idEx(idEx),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.memFwd(exMem.result),
		.wbFwd(memWb.wbData),
		.result(exResult),
		.storeData(exStoreData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	assign instrAddr = pc;

	// everything freezes while a data request waits
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `CORE_RESET_PC;
			ifId <= '0;
			idEx <= '0;
			exMem <= '0;
			memWb <= '0;
		end else if (!memStall) begin
			if (flushIf)
				pc <= branchTarget;
			else if (!stall)
				pc <= pc + 32'd4;

			// the delay slot is already in ID so only IF is dropped
			if (flushIf)
				ifId <= '0;
			else if (!stall)
				ifId <= '{valid: 1'b1, pc: pc, instr: instr};

			if (stall) begin
				idEx <= '0;
			end else begin
				idEx.valid <= ifId.valid;
				idEx.pc <= ifId.pc;
				idEx.ctrl <= idCtrl;
				idEx.rs <= ifId.instr[25:21];
				idEx.rt <= ifId.instr[20:16];
				idEx.rsVal <= rsVal;
				idEx.rtVal <= rtVal;
				idEx.imm <= idImm;
			end

			exMem.valid <= idEx.valid;
			exMem.pc <= idEx.pc;
			exMem.regWrite <= idEx.valid && idEx.ctrl.regWrite;
			exMem.memRead <= idEx.valid && idEx.ctrl.memRead;
			exMem.memWrite <= idEx.valid && idEx.ctrl.memWrite;
			exMem.dest <= idEx.ctrl.dest;
			exMem.result <= exResult;
			exMem.storeData <= exStoreData;

			memWb.valid <= exMem.valid;
			memWb.pc <= exMem.pc;
			memWb.regWrite <= exMem.regWrite;
			memWb.dest <= exMem.dest;
			memWb.wbData <= exMem.memRead ? dataRdata : exMem.result;
		end
	end

	assign dataReq = exMem.valid && (exMem.memRead || exMem.memWrite);
	assign dataWe = exMem.memWrite;
	assign dataAddr = exMem.result;
	assign dataWdata = exMem.storeData;

	assign debugWbPc = memWb.pc;
	assign debugWbRfWen = {4{wbWrite}};
	assign debugWbRfWnum = memWb.dest;
	assign debugWbRfWdata = memWb.wbData;

	// request must not move until acknowledged
	assert property (@(posedge clk) disable iff (!arstN)
		dataReq && !dataOk |=> dataReq && $stable(dataAddr) && $stable(dataWe)
			&& $stable(dataWdata))
		else $error("data request changed before dataOk");

	// one pulse per retiring instruction
	assert property (@(posedge clk) disable iff (!arstN)
		debugWbRfWen != 4'b0000 |=> debugWbRfWen == 4'b0000
			|| debugWbPc != $past(debugWbPc))
		else $error("writeback reported twice for one instruction");

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
	parameter int halfPeriod = 20,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic arstN
);
	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// release between edges
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN <= 1'b1;
	end

endmodule

// ==== sim/tbMips.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module tbMips import mipsPkg::*; ();
	logic clk;
	logic arstN;
	word_t instrAddr;
	instr_t instr;
	logic dataReq;
	logic dataWe;
	word_t dataAddr;
	word_t dataWdata;
	logic dataOk = 1'b0;
	word_t dataRdata = '0;
	word_t debugWbPc;
	logic [3:0] debugWbRfWen;
	regAddr_t debugWbRfWnum;
	word_t debugWbRfWdata;

	instr_t prog [64];
	int progLen;
	word_t dmem [64];
	integer seed = 32'h632a4943;
	logic pending = 1'b0;
	int waitLeft;

	// expected writebacks in retire order
	word_t expPc [$];
	regAddr_t expReg [$];
	word_t expVal [$];
	int gotCount = 0;
	int checkErrors = 0;
	int waitErrors = 0;

	// expected data accesses in program order
	logic expWe [$];
	word_t expAddr [$];
	word_t expWdata [$];
	int accessCount = 0;

	clockGen uClk (
		.clk(clk),
		.arstN(arstN)
	);

	mipsCore uut (
		.clk(clk),
		.arstN(arstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.dataReq(dataReq),
		.dataWe(dataWe),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataOk(dataOk),
		.dataRdata(dataRdata),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	// nops past the program window
	assign instr = (instrAddr < 32'd256) ? prog[instrAddr[7:2]] : '0;

	function automatic word_t fillWord(word_t addr);
		return (addr ^ 32'h5a5a_a5a5) + {addr[15:0], addr[31:16]};
	endfunction

	function automatic instr_t rType(int rs, int rt, int rd, logic [5:0] fn);
		return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic instr_t iType(logic [5:0] op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	task automatic emit(instr_t word);
		prog[progLen] = word;
		progLen++;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < 64; i++)
			prog[i] = '0;
		progLen = 0;
		// dependent alu chain
		emit(iType(`OP_ADDIU, 0, 1, 5));
		emit(iType(`OP_ADDIU, 0, 2, 14));
		emit(rType(1, 2, 3, `FN_ADDU));
		emit(rType(3, 1, 4, `FN_SUBU));
		emit(rType(4, 3, 5, `FN_AND));
		emit(rType(5, 4, 6, `FN_OR));
		emit(rType(1, 6, 7, `FN_SLT));
		emit(iType(`OP_LUI, 0, 8, 32'h8234));
		emit(iType(`OP_ADDIU, 8, 8, -1));
		emit(rType(0, 1, 10, `FN_SUBU));
		emit(rType(10, 1, 9, `FN_SLT));
		// store, load back, load-use
		emit(iType(`OP_ADDIU, 0, 11, 32'h40));
		emit(iType(`OP_SW, 11, 8, 0));
		emit(iType(`OP_LW, 11, 12, 0));
		emit(rType(12, 1, 13, `FN_ADDU));
		emit(iType(`OP_SW, 11, 13, 4));
		emit(iType(`OP_LW, 11, 14, 4));
		emit(iType(`OP_LW, 11, 15, 8));
		// taken branches skip one word after the slot
		emit(iType(`OP_BEQ, 1, 1, 2));
		emit(iType(`OP_ADDIU, 0, 16, 1));
		emit(iType(`OP_ADDIU, 0, 17, 2));
		emit(iType(`OP_ADDIU, 0, 18, 3));
		emit(iType(`OP_BNE, 1, 2, 2));
		emit(iType(`OP_ADDIU, 0, 19, 4));
		emit(iType(`OP_ADDIU, 0, 20, 5));
		emit(iType(`OP_BEQ, 1, 2, 2));
		emit(iType(`OP_ADDIU, 0, 21, 6));
		emit(iType(`OP_ADDIU, 0, 22, 7));
		emit(iType(`OP_BNE, 1, 1, 2));
		emit(iType(`OP_ADDIU, 0, 23, 8));
		emit(iType(`OP_ADDIU, 0, 24, 9));
		// branch operand comes from MEM
		emit(iType(`OP_ADDIU, 0, 25, 5));
		emit(iType(`OP_BEQ, 25, 1, 2));
		emit(rType(25, 1, 26, `FN_ADDU));
		emit(iType(`OP_ADDIU, 0, 27, 10));
		emit(rType(25, 26, 28, `FN_OR));
	endtask

	// ISA-level model with delay slots
	function automatic void refRun();
		word_t r [32];
		word_t rm [64];
		word_t pc;
		word_t npc;
		word_t followPc;
		word_t ins;
		word_t imm;
		word_t a;
		word_t b;
		word_t addr;
		word_t val;
		regAddr_t dst;
		logic wr;
		int steps;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		for (int i = 0; i < 64; i++)
			rm[i] = fillWord(word_t'(i) << 2);
		pc = `CORE_RESET_PC;
		npc = pc + 32'd4;
		steps = 0;
		while (pc < (word_t'(progLen) << 2) && steps < 500) begin
			ins = prog[pc[7:2]];
			imm = {{16{ins[15]}}, ins[15:0]};
			a = r[ins[25:21]];
			b = r[ins[20:16]];
			addr = a + imm;
			dst = ins[20:16];
			wr = 1'b1;
			val = '0;
			followPc = npc + 32'd4;
			case (ins[31:26])
				`OP_SPECIAL: begin
					dst = ins[15:11];
					case (ins[5:0])
						`FN_ADDU: val = a + b;
						`FN_SUBU: val = a - b;
						`FN_AND: val = a & b;
						`FN_OR: val = a | b;
						`FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				`OP_ADDIU: val = a + imm;
				`OP_LUI: val = {ins[15:0], 16'h0000};
				`OP_LW: begin
					val = rm[addr[7:2]];
					expWe.push_back(1'b0);
					expAddr.push_back(addr);
					expWdata.push_back(32'd0);
				end
				`OP_SW: begin
					rm[addr[7:2]] = b;
					wr = 1'b0;
					expWe.push_back(1'b1);
					expAddr.push_back(addr);
					expWdata.push_back(b);
				end
				`OP_BEQ: begin
					wr = 1'b0;
					if (a == b)
						followPc = pc + 32'd4 + (imm << 2);
				end
				`OP_BNE: begin
					wr = 1'b0;
					if (a != b)
						followPc = pc + 32'd4 + (imm << 2);
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != '0) begin
				r[dst] = val;
				expPc.push_back(pc);
				expReg.push_back(dst);
				expVal.push_back(val);
			end
			pc = npc;
			npc = followPc;
			steps++;
		end
	endfunction

	task automatic checkAccess();
		if (accessCount >= expAddr.size()) begin
			$display("unexpected data access at %0t to address %h", $time, dataAddr);
			checkErrors++;
		end else begin
			if (dataWe != expWe[accessCount]) begin
				$display("Mismatch at %0t: dataWe got %b expected %b",
					$time, dataWe, expWe[accessCount]);
				checkErrors++;
			end
			if (dataAddr != expAddr[accessCount]) begin
				$display("Mismatch at %0t: dataAddr got %h expected %h",
					$time, dataAddr, expAddr[accessCount]);
				checkErrors++;
			end
			if (expWe[accessCount] && dataWdata != expWdata[accessCount]) begin
				$display("Mismatch at %0t: dataWdata got %h expected %h",
					$time, dataWdata, expWdata[accessCount]);
				checkErrors++;
			end
		end
		accessCount++;
	endtask

	// acks each request after 0 to 3 extra cycles
	always @(negedge clk) begin
		if (!arstN) begin
			for (int i = 0; i < 64; i++)
				dmem[i] = fillWord(word_t'(i) << 2);
			pending = 1'b0;
			dataOk = 1'b0;
		end else if (dataReq) begin
			if (!pending) begin
				pending = 1'b1;
				waitLeft = $random(seed) & 3;
			end
			if (waitLeft == 0) begin
				pending = 1'b0;
				dataOk = 1'b1;
				checkAccess();
				if (dataWe)
					dmem[dataAddr[7:2]] = dataWdata;
				else
					dataRdata = dmem[dataAddr[7:2]];
			end else begin
				waitLeft--;
				dataOk = 1'b0;
			end
		end else begin
			dataOk = 1'b0;
		end
	end

	task automatic checkWriteback();
		if (gotCount >= expPc.size()) begin
			$display("unexpected extra writeback at %0t from pc %h", $time, debugWbPc);
			checkErrors++;
		end else begin
			if (debugWbRfWen != 4'hf) begin
				$display("Mismatch at %0t: debugWbRfWen got %h expected f", $time, debugWbRfWen);
				checkErrors++;
			end
			if (debugWbPc != expPc[gotCount]) begin
				$display("Mismatch at %0t: debugWbPc got %h expected %h",
					$time, debugWbPc, expPc[gotCount]);
				checkErrors++;
			end
			if (debugWbRfWnum != expReg[gotCount]) begin
				$display("Mismatch at %0t: debugWbRfWnum got %0d expected %0d",
					$time, debugWbRfWnum, expReg[gotCount]);
				checkErrors++;
			end
			if (debugWbRfWdata != expVal[gotCount]) begin
				$display("Mismatch at %0t: debugWbRfWdata got %h expected %h",
					$time, debugWbRfWdata, expVal[gotCount]);
				checkErrors++;
			end
		end
		gotCount++;
	endtask

	always @(posedge clk) begin
		if (!arstN) begin
			if (dataReq || debugWbRfWen != 4'h0) begin
				$display("dataReq or debugWbRfWen active during reset at %0t", $time);
				checkErrors++;
			end
			if (instrAddr != `CORE_RESET_PC) begin
				$display("Mismatch at %0t: instrAddr got %h expected %h",
					$time, instrAddr, `CORE_RESET_PC);
				checkErrors++;
			end
		end else begin
			if (gotCount == 0 && dataReq) begin
				$display("dataReq raised before the first writeback at %0t", $time);
				checkErrors++;
			end
			if (debugWbRfWen != 4'h0)
				checkWriteback();
		end
	end

	initial begin
		int waited;
		loadProgram();
		refRun();
		waited = 0;
		while (!arstN && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (!arstN) begin
			$display("reset was never released");
			waitErrors++;
		end
		waited = 0;
		while (gotCount < expPc.size() && waited < 3000) begin
			@(negedge clk);
			waited++;
		end
		if (gotCount < expPc.size()) begin
			$display("timed out with %0d of %0d writebacks seen", gotCount, expPc.size());
			waitErrors++;
		end
		// window to catch late duplicates
		repeat (20) @(negedge clk);
		if (accessCount != expAddr.size()) begin
			$display("saw %0d data accesses where %0d were expected",
				accessCount, expAddr.size());
			checkErrors++;
		end
		$display("writebacks %0d of %0d, accesses %0d of %0d, check errors %0d, wait errors %0d",
			gotCount, expPc.size(), accessCount, expAddr.size(), checkErrors, waitErrors);
		if (checkErrors == 0 && waitErrors == 0 && gotCount == expPc.size())
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+design
design/mipsPkg.sv
design/regFile.sv
design/decoder.sv
design/hazardUnit.sv
design/alu.sv
design/mipsCore.sv
sim/clockGen.sv
sim/tbMips.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbMips -f verilog.f &&
./obj_dir/VtbMips | tee /dev/stderr | grep -x "All tests passed" > /dev/null &&
echo "PASS" || { echo "FAIL"; exit 1; }
